//--- source/tomasuloPkg.sv
package tomasuloPkg;

   // ----------------------------------------------------------------------
   // Sizes and latencies
   // ----------------------------------------------------------------------
   localparam int DataWidth     = 16;  // Register value width
   localparam int RegCount      = 16;  // Architectural registers
   localparam int ProgDepth     = 64;  // Program memory words
   localparam int RobDepth      = 4;   // Value table entries
   localparam int StationDepth  = 2;   // Entries per station
   localparam int AddSubLatency = 2;   // Start to result, add/sub
   localparam int MulLatency    = 3;   // Start to result, mul
   localparam int DivLatency    = 4;   // Start to result, div

   typedef logic [3:0] regIdxT;                          // Register index
   typedef logic [5:0] pcT;                              // Program address
   typedef logic [1:0] robTagT;                          // Value table index and tag
   typedef logic [$clog2(StationDepth)-1:0] slotT;       // Station entry index

   // One opcode per nibble position 15:12
   typedef enum logic [3:0] {
      OpStall = 4'd0,
      OpAdd   = 4'd1,
      OpSub   = 4'd2,
      OpMul   = 4'd3,
      OpDiv   = 4'd4
   } opcodeT;

   // ----------------------------------------------------------------------
   // Structs passed between modules
   // ----------------------------------------------------------------------
   typedef struct packed {
      opcodeT op;      // Operation
      regIdxT dest;    // Destination
      regIdxT srcJ;    // First source
      regIdxT srcK;    // Second source
   } instrT;

   typedef struct packed {
      logic                 ready;  // Value valid
      logic [DataWidth-1:0] value;
      robTagT               tag;    // Producer when not ready
   } operandT;

   typedef struct packed {
      logic    valid;
      opcodeT  op;
      robTagT  robTag;   // Allocated table entry
      operandT opJ;
      operandT opK;
   } dispatchT;

   typedef struct packed {
      logic                 valid;
      robTagT               tag;
      logic [DataWidth-1:0] value;
   } cdbT;

   typedef struct packed {
      logic                 valid;
      regIdxT               dest;
      robTagT               tag;
      logic [DataWidth-1:0] value;
   } commitT;

   typedef struct packed {
      logic                 valid;
      opcodeT               op;
      logic [DataWidth-1:0] a;
      logic [DataWidth-1:0] b;
      robTagT               tag;
   } execReqT;

endpackage

//--- source/issueUnit.sv
`timescale 1ns/100ps

module issueUnit
   import tomasuloPkg::*;
(
   input  logic     Clock,
   input  logic     rst,
   input  logic     progWrite,
   input  pcT       progAddr,
   input  instrT    progWord,
   input  logic     start,
   input  logic [6:0] progLength,
   input  logic     robFree,
   input  logic     addFree,
   input  logic     mulFree,
   input  robTagT   robTag,
   input  operandT  opJ,
   input  operandT  opK,
   output regIdxT   srcJ,
   output regIdxT   srcK,
   output regIdxT   dest,
   output dispatchT dispatch,
   input  logic     robEmpty,
   output logic     done
);

   instrT      progMem [ProgDepth];  // Program store
   logic [6:0] pc;                   // One bit wider than pcT to reach 64
   logic [6:0] progLen;              // Latched at start
   logic       running;
   instrT      instr;
   logic       pending;              // Instructions left to issue
   logic       isAdd;
   logic       isMul;
   logic       stationFree;
   logic       canIssue;
   logic       advance;

   always_ff @(posedge Clock)
   begin
      if (progWrite)
         progMem[progAddr] <= progWord;          // Testbench load port
   end

   // ----------------------------------------------------------------------
   // Decode and dispatch decision
   // ----------------------------------------------------------------------
   assign instr       = progMem[pcT'(pc)];
   assign srcJ        = instr.srcJ;
   assign srcK        = instr.srcK;
   assign dest        = instr.dest;
   assign pending     = running && (pc < progLen);
   assign isAdd       = instr.op inside {OpAdd, OpSub};
   assign isMul       = instr.op inside {OpMul, OpDiv};
   assign stationFree = isMul ? mulFree : addFree;   // Route by class
   assign canIssue    = pending && (isAdd || isMul) && robFree && stationFree;
   assign advance     = canIssue || (pending && !isAdd && !isMul);  // Stall just skips

   always_comb
   begin
      dispatch.valid  = canIssue;
      dispatch.op     = instr.op;
      dispatch.robTag = robTag;          // Tail entry doubles as tag
      dispatch.opJ    = opJ;
      dispatch.opK    = opK;
   end

   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         pc      <= '0;
         progLen <= '0;
         running <= 1'b0;
         done    <= 1'b0;
      end
      else if (start)
      begin
         pc      <= '0;                  // Restart from address 0
         progLen <= progLength;
         running <= 1'b1;
         done    <= 1'b0;
      end
      else
      begin
         if (advance)
            pc <= pc + 7'd1;
         done <= running && (pc == progLen) && robEmpty;  // All issued and drained
      end
   end

   // Nothing issues once the program is reported done
   assert property (@(posedge Clock) disable iff (rst) done |-> !dispatch.valid);

endmodule

//--- source/registerStatus.sv
`timescale 1ns/100ps

module registerStatus
   import tomasuloPkg::*;
(
   input  logic                     Clock,
   input  logic                     rst,
   input  regIdxT                   srcJ,
   input  regIdxT                   srcK,
   input  regIdxT                   dest,
   input  dispatchT                 dispatch,
   input  operandT [RobDepth-1:0]   robPeek,
   input  commitT                   commit,
   input  regIdxT                   regAddr,
   output logic [DataWidth-1:0]     regData,
   output operandT                  opJ,
   output operandT                  opK
);

   logic [DataWidth-1:0] regs [RegCount];     // Committed values
   robTagT               tags [RegCount];     // Latest producer
   logic                 pendingMark [RegCount];

   // Register file, then value table, else wait on tag
   function automatic operandT lookup(regIdxT r);
      operandT o;
      operandT peek;
      peek    = robPeek[tags[r]];
      o.ready = 1'b1;
      o.value = regs[r];
      o.tag   = tags[r];
      if (pendingMark[r])
      begin
         o.ready = peek.ready;           // Result may already sit in the table
         o.value = peek.value;
      end
      return o;
   endfunction

   assign opJ     = lookup(srcJ);
   assign opK     = lookup(srcK);
   assign regData = regs[regAddr];       // Debug read port

   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         for (int i = 0; i < RegCount; i++)
         begin
            regs[i]        <= DataWidth'(i);   // Each register holds its index
            pendingMark[i] <= 1'b0;
         end
      end
      else
      begin
         if (commit.valid)
         begin
            regs[commit.dest] <= commit.value;
            if (tags[commit.dest] == commit.tag)
               pendingMark[commit.dest] <= 1'b0;  // Later rename keeps its mark
         end
         if (dispatch.valid)
         begin
            pendingMark[dest] <= 1'b1;   // Rename wins over same-cycle commit
            tags[dest]        <= dispatch.robTag;
         end
      end
   end

endmodule

//--- source/reservationStation.sv
`timescale 1ns/100ps

module reservationStation
   import tomasuloPkg::*;
#(
   parameter bit AcceptMul = 1'b0         // Set for the mul/div station
)
(
   input  logic     Clock,
   input  logic     rst,
   input  dispatchT dispatch,
   input  cdbT      cdb,
   input  logic     unitIdle,
   input  logic     grantMine,
   output execReqT  execReq,
   output logic     free
);

   dispatchT entry [StationDepth];   // valid doubles as busy
   logic     started [StationDepth]; // Entry handed to the unit
   slotT     runIdx;                 // Entry now in the unit
   slotT     freeIdx;
   slotT     reqIdx;
   logic     reqHit;
   logic     mine;
   dispatchT incoming;

   // Bus snoop for one operand
   function automatic operandT wake(operandT o);
      operandT w;
      w = o;
      if (!o.ready && cdb.valid && (cdb.tag == o.tag))
      begin
         w.ready = 1'b1;
         w.value = cdb.value;
      end
      return w;
   endfunction

   assign mine = dispatch.valid && ((dispatch.op inside {OpMul, OpDiv}) == AcceptMul);

   always_comb
   begin
      incoming     = dispatch;
      incoming.opJ = wake(dispatch.opJ);   // Same-cycle broadcast is not lost
      incoming.opK = wake(dispatch.opK);
   end

   // ----------------------------------------------------------------------
   // Free slot and ready pick, lowest index wins
   // ----------------------------------------------------------------------
   always_comb
   begin
      free    = 1'b0;
      freeIdx = '0;
      reqHit  = 1'b0;
      reqIdx  = '0;
      for (int i = StationDepth - 1; i >= 0; i--)
      begin
         if (!entry[i].valid)
         begin
            free    = 1'b1;
            freeIdx = slotT'(i);
         end
         if (entry[i].valid && !started[i] && entry[i].opJ.ready && entry[i].opK.ready)
         begin
            reqHit = 1'b1;
            reqIdx = slotT'(i);
         end
      end
   end

   always_comb
   begin
      execReq.valid = reqHit && unitIdle;    // One-cycle start strobe
      execReq.op    = entry[reqIdx].op;
      execReq.a     = entry[reqIdx].opJ.value;
      execReq.b     = entry[reqIdx].opK.value;
      execReq.tag   = entry[reqIdx].robTag;
   end

   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         for (int i = 0; i < StationDepth; i++)
         begin
            entry[i].valid <= 1'b0;
            started[i]     <= 1'b0;
         end
         runIdx <= '0;
      end
      else
      begin
         for (int i = 0; i < StationDepth; i++)
         begin
            entry[i].opJ <= wake(entry[i].opJ);
            entry[i].opK <= wake(entry[i].opK);
         end
         if (execReq.valid)
         begin
            started[reqIdx] <= 1'b1;
            runIdx          <= reqIdx;
         end
         if (grantMine)
         begin
            entry[runIdx].valid <= 1'b0;   // Result left on the bus
            started[runIdx]     <= 1'b0;
         end
         if (mine)
         begin
            entry[freeIdx]   <= incoming;
            started[freeIdx] <= 1'b0;
         end
      end
   end

   // Bus grant only for an entry the unit is running
   assert property (@(posedge Clock) disable iff (rst)
      grantMine |-> entry[runIdx].valid && started[runIdx]);

endmodule

//--- source/addSubUnit.sv
`timescale 1ns/100ps

module addSubUnit
   import tomasuloPkg::*;
(
   input  logic    Clock,
   input  logic    rst,
   input  execReqT execReq,
   input  logic    grant,
   output logic    idle,
   output cdbT     result
);

   logic       busy;
   logic [2:0] cnt;       // Cycles left
   execReqT    job;       // Held operands

   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         cnt  <= '0;
      end
      else if (execReq.valid)
      begin
         busy <= 1'b1;
         cnt  <= 3'(AddSubLatency - 1);
         job  <= execReq;
      end
      else if (grant)
         busy <= 1'b0;                  // Bus took the result
      else if (busy && (cnt != '0))
         cnt <= cnt - 3'd1;
   end

   assign idle         = !busy;
   assign result.valid = busy && (cnt == '0);   // Held until granted
   assign result.tag   = job.tag;
   assign result.value = (job.op == OpSub) ? job.a - job.b : job.a + job.b;

endmodule

//--- source/mulDivUnit.sv
`timescale 1ns/100ps

module mulDivUnit
   import tomasuloPkg::*;
(
   input  logic    Clock,
   input  logic    rst,
   input  execReqT execReq,
   input  logic    grant,
   output logic    idle,
   output cdbT     result
);

   logic                 busy;
   logic [2:0]           cnt;       // Cycles left
   execReqT              job;
   logic [DataWidth-1:0] quotient;

   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         cnt  <= '0;
      end
      else if (execReq.valid)
      begin
         busy <= 1'b1;
         cnt  <= (execReq.op == OpDiv) ? 3'(DivLatency - 1) : 3'(MulLatency - 1);
         job  <= execReq;
      end
      else if (grant)
         busy <= 1'b0;
      else if (busy && (cnt != '0))
         cnt <= cnt - 3'd1;
   end

   // Zero divisor gives all ones
   assign quotient = (job.b == '0) ? '1 : job.a / job.b;

   assign idle         = !busy;
   assign result.valid = busy && (cnt == '0);
   assign result.tag   = job.tag;
   assign result.value = (job.op == OpDiv) ? quotient : job.a * job.b;  // Low 16 bits

   // Station must wait for idle before starting a new job
   assert property (@(posedge Clock) disable iff (rst) execReq.valid |-> !busy);

endmodule

//--- source/reorderBuffer.sv
`timescale 1ns/100ps

module reorderBuffer
   import tomasuloPkg::*;
(
   input  logic                     Clock,
   input  logic                     rst,
   input  dispatchT                 dispatch,
   input  regIdxT                   dest,
   input  cdbT                      cdb,
   output logic                     robFree,
   output robTagT                   robTag,
   output logic                     robEmpty,
   output operandT [RobDepth-1:0]   robPeek,
   output commitT                   commit
);

   logic                 present [RobDepth];  // Result written
   regIdxT               destReg [RobDepth];
   logic [DataWidth-1:0] value [RobDepth];
   robTagT               head;                // Oldest entry
   robTagT               tail;                // Next allocation
   logic [$clog2(RobDepth):0] count;

   assign robFree  = (count != RobDepth);
   assign robEmpty = (count == '0);
   assign robTag   = tail;

   always_comb
   begin
      for (int i = 0; i < RobDepth; i++)
      begin
         robPeek[i].ready = present[i];
         robPeek[i].value = value[i];
         robPeek[i].tag   = robTagT'(i);
      end
   end

   // In-order commit of the head
   assign commit.valid = !robEmpty && present[head];
   assign commit.dest  = destReg[head];
   assign commit.tag   = head;
   assign commit.value = value[head];

   // ----------------------------------------------------------------------
   // Allocate, fill, retire
   // ----------------------------------------------------------------------
   always_ff @(posedge Clock)
   begin
      if (rst)
      begin
         for (int i = 0; i < RobDepth; i++)
            present[i] <= 1'b0;
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         if (cdb.valid)
         begin
            present[cdb.tag] <= 1'b1;   // Match by tag
            value[cdb.tag]   <= cdb.value;
         end
         if (commit.valid)
         begin
            present[head] <= 1'b0;
            head          <= head + robTagT'(1);
         end
         if (dispatch.valid)
         begin
            present[tail] <= 1'b0;
            destReg[tail] <= dest;
            tail          <= tail + robTagT'(1);
         end
         count <= count + (dispatch.valid ? 1'b1 : 1'b0) - (commit.valid ? 1'b1 : 1'b0);
      end
   end

   // Bus never rewrites a head that is retiring
   assert property (@(posedge Clock) disable iff (rst)
      commit.valid |-> !(cdb.valid && (cdb.tag == head)));

endmodule

//--- source/tomasuloCore.sv
`timescale 1ns/100ps

module tomasuloCore
   import tomasuloPkg::*;
(
   input  logic                 Clock,
   input  logic                 rst,
   input  logic                 progWrite,
   input  pcT                   progAddr,
   input  instrT                progWord,
   input  logic                 start,
   input  logic [6:0]           progLength,
   input  regIdxT               regAddr,
   output logic [DataWidth-1:0] regData,
   output logic                 done
);

   logic                   robFree;
   logic                   robEmpty;
   logic                   addFree;
   logic                   mulFree;
   robTagT                 robTag;
   operandT                opJ;
   operandT                opK;
   regIdxT                 srcJ;
   regIdxT                 srcK;
   regIdxT                 dest;
   dispatchT               dispatch;
   operandT [RobDepth-1:0] robPeek;
   commitT                 commit;
   execReqT                addReq;
   execReqT                mulReq;
   logic                   addIdle;
   logic                   mulIdle;
   cdbT                    addResult;
   cdbT                    mulResult;
   logic                   grantAdd;
   logic                   grantMul;
   cdbT                    cdb;

   // ----------------------------------------------------------------------
   // Bus grant, mul/div first
   // ----------------------------------------------------------------------
   assign grantMul = mulResult.valid;
   assign grantAdd = addResult.valid && !mulResult.valid;
   assign cdb      = grantMul ? mulResult : (grantAdd ? addResult : '0);

   issueUnit u_issue (
      .Clock, .rst, .progWrite, .progAddr, .progWord, .start, .progLength,
      .robFree, .addFree, .mulFree, .robTag, .opJ, .opK,
      .srcJ, .srcK, .dest, .dispatch, .robEmpty, .done
   );

   registerStatus u_regs (
      .Clock, .rst, .srcJ, .srcK, .dest, .dispatch, .robPeek, .commit,
      .regAddr, .regData, .opJ, .opK
   );

   reservationStation #(.AcceptMul(1'b0)) addStation (
      .Clock, .rst, .dispatch, .cdb,
      .unitIdle(addIdle), .grantMine(grantAdd), .execReq(addReq), .free(addFree)
   );

   reservationStation #(.AcceptMul(1'b1)) mulStation (
      .Clock, .rst, .dispatch, .cdb,
      .unitIdle(mulIdle), .grantMine(grantMul), .execReq(mulReq), .free(mulFree)
   );

   addSubUnit u_addSub (
      .Clock, .rst, .execReq(addReq), .grant(grantAdd), .idle(addIdle), .result(addResult)
   );

   mulDivUnit u_mulDiv (
      .Clock, .rst, .execReq(mulReq), .grant(grantMul), .idle(mulIdle), .result(mulResult)
   );

   reorderBuffer u_rob (
      .Clock, .rst, .dispatch, .dest, .cdb,
      .robFree, .robTag, .robEmpty, .robPeek, .commit
   );

endmodule

//--- verif/tbClock.sv
`timescale 1ns/100ps

module tbClock
#(
   parameter int HalfPeriod = 20     // 40 ns period
)
(
   output logic Clock
);

   initial
   begin
      Clock = 1'b0;
      forever
         #HalfPeriod Clock = ~Clock;
   end

endmodule

//--- verif/tomasuloTb.sv
`timescale 1ns/100ps

module tomasuloTb
   import tomasuloPkg::*;
();

   localparam int TotalInstr    = 27;                // Instructions over all five tests
   localparam int TimeoutCycles = 200 * TotalInstr;
   localparam int DriveDelay    = 2;                 // ns after the rising edge

   logic                 Clock;
   logic                 rst;
   logic                 progWrite;
   pcT                   progAddr;
   instrT                progWord;
   logic                 start;
   logic [6:0]           progLength;
   regIdxT               regAddr;
   logic [DataWidth-1:0] regData;
   logic                 done;

   instrT                prog [ProgDepth];  // Program under test
   int                   progSize;
   logic [DataWidth-1:0] model [RegCount];  // In-order reference state
   logic [31:0]          lcgState;
   int                   errorCount;
   int                   checkCount;
   int                   cycleCount;

   tbClock clockGen (.Clock);

   tomasuloCore i_dut (
      .Clock, .rst, .progWrite, .progAddr, .progWord, .start, .progLength,
      .regAddr, .regData, .done
   );

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
      return lcgState;
   endfunction

   // One reference step, 16-bit wraparound
   function automatic logic [DataWidth-1:0] evalOp(opcodeT op, logic [DataWidth-1:0] a,
                                                   logic [DataWidth-1:0] b);
      logic [31:0] product;
      product = a * b;                  // Full product, low half kept
      case (op)
         OpAdd:   return a + b;
         OpSub:   return a - b;
         OpMul:   return product[15:0];
         OpDiv:   return (b == 16'd0) ? 16'hffff : a / b;
         default: return a;
      endcase
   endfunction

   task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAIL at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   task automatic afterEdge();
      @(posedge Clock);
      #DriveDelay;
   endtask

   task automatic applyReset();
      afterEdge();
      rst = 1'b1;
      repeat (2) afterEdge();           // Two rising edges in reset
      rst = 1'b0;
   endtask

   task automatic clearProgram();
      progSize = 0;
   endtask

   task automatic appendInstr(opcodeT op, int d, int j, int k);
      prog[progSize].op   = op;
      prog[progSize].dest = regIdxT'(d);
      prog[progSize].srcJ = regIdxT'(j);
      prog[progSize].srcK = regIdxT'(k);
      progSize++;
   endtask

   task automatic computeModel();
      for (int i = 0; i < RegCount; i++)
         model[i] = DataWidth'(i);      // Reset value is the index
      for (int n = 0; n < progSize; n++)
      begin
         if (prog[n].op != OpStall)
            model[prog[n].dest] = evalOp(prog[n].op, model[prog[n].srcJ], model[prog[n].srcK]);
      end
   endtask

   task automatic loadProgram();
      for (int n = 0; n < progSize; n++)
      begin
         afterEdge();
         progWrite = 1'b1;              // One word per cycle
         progAddr  = pcT'(n);
         progWord  = prog[n];
      end
      afterEdge();
      progWrite = 1'b0;
   endtask

   task automatic startAndWait();
      afterEdge();
      start      = 1'b1;
      progLength = 7'(progSize);
      afterEdge();
      start = 1'b0;
      while (done !== 1'b1)
         @(negedge Clock);              // Timeout process guards this loop
   endtask

   task automatic checkRegisters();
      computeModel();
      for (int i = 0; i < RegCount; i++)
      begin
         afterEdge();
         regAddr = regIdxT'(i);
         @(negedge Clock);              // Read port settled
         checkValue($sformatf("regData[r%0d]", i), regData, model[i]);
      end
   endtask

   task automatic executeAndCheck();
      loadProgram();
      startAndWait();
      checkRegisters();
   endtask

   // ----------------------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------------------
   task automatic testIndependent();
      $display("Test 1: independent add and sub");
      applyReset();
      clearProgram();
      appendInstr(OpAdd, 4, 1, 2);
      appendInstr(OpSub, 5, 7, 3);
      appendInstr(OpAdd, 6, 8, 9);
      appendInstr(OpSub, 10, 2, 11);    // Wraps below zero
      executeAndCheck();
   endtask

   task automatic testDependentChain();
      $display("Test 2: chain of true dependences");
      applyReset();
      clearProgram();
      appendInstr(OpAdd, 0, 1, 2);
      appendInstr(OpAdd, 0, 0, 3);      // Waits on the first result
      executeAndCheck();
   endtask

   task automatic testMulDivBus();
      $display("Test 3: mul and div against adds on the bus");
      applyReset();
      clearProgram();
      appendInstr(OpMul, 4, 5, 6);
      appendInstr(OpAdd, 7, 9, 10);
      appendInstr(OpDiv, 8, 12, 3);
      appendInstr(OpSub, 1, 4, 2);      // Needs the product
      appendInstr(OpDiv, 11, 13, 0);    // r0 is zero
      appendInstr(OpAdd, 2, 8, 11);
      executeAndCheck();
   endtask

   task automatic testStationFull();
      $display("Test 4: three adds fill the add station");
      applyReset();
      clearProgram();
      appendInstr(OpAdd, 1, 2, 3);
      appendInstr(OpAdd, 4, 1, 5);
      appendInstr(OpAdd, 7, 4, 1);      // Third one stalls issue
      executeAndCheck();
   endtask

   task automatic testRandomProgram();
      logic [31:0] r;
      $display("Test 5: random program of 12 instructions");
      applyReset();
      clearProgram();
      for (int n = 0; n < 12; n++)
      begin
         r = nextRandom();
         appendInstr(opcodeT'(r[31:16] % 16'd5), r[15:12], r[11:8], r[7:4]);
      end
      executeAndCheck();
      checkValue("done", done, 32'd1);  // Still high after the drain
   endtask

   // ----------------------------------------------------------------------
   // Run control
   // ----------------------------------------------------------------------
   initial
   begin
      rst        = 1'b1;
      progWrite  = 1'b0;
      progAddr   = '0;
      progWord   = '0;
      start      = 1'b0;
      progLength = '0;
      regAddr    = '0;
      lcgState   = 32'h5b2c_03d2;
      errorCount = 0;
      checkCount = 0;
      progSize   = 0;

      testIndependent();
      testDependentChain();
      testMulDivBus();
      testStationFull();
      testRandomProgram();

      $display("Summary: %0d compares, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial
   begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles)
      begin
         @(posedge Clock);
         cycleCount++;
      end
      $display("Timeout: run not finished after %0d cycles, %0d errors so far",
               TimeoutCycles, errorCount);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- tb.f
source/tomasuloPkg.sv
source/issueUnit.sv
source/registerStatus.sv
source/reservationStation.sv
source/addSubUnit.sv
source/mulDivUnit.sv
source/reorderBuffer.sv
source/tomasuloCore.sv
verif/tbClock.sv
verif/tomasuloTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tomasuloTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
